// ==== logic/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // queue sizing
    localparam int iq_depth    = 8;
    localparam int iq_cnt_w    = 4;
    localparam int iq_idx_w    = $clog2(iq_depth);
    localparam int alloc_width = 2;
    localparam int wb_ports    = 2;

    // register file, ROB and tag widths
    localparam int preg_w = 7;
    localparam int rob_w  = 6;
    localparam int tag_w  = 4;

    typedef logic [preg_w-1:0]   preg_t;
    typedef logic [rob_w-1:0]    rob_idx_t;
    typedef logic [tag_w-1:0]    lsu_tag_t;
    typedef logic [iq_cnt_w-1:0] iq_cnt_t;
    typedef logic [iq_idx_w-1:0] iq_idx_t;

    typedef enum logic [1:0] {
        kind_load  = 2'd0,
        kind_store = 2'd1,
        kind_dbar  = 2'd2,
        kind_ibar  = 2'd3
    } op_kind_t;

    // one renamed memory operation as it leaves rename
    typedef struct packed {
        op_kind_t kind;
        rob_idx_t rob;
        preg_t    rj;
        logic     rj_exist;
        logic     rj_ready;
        preg_t    rk;
        logic     rk_exist;
        logic     rk_ready;
    } alloc_req_t;

    // queue entry adds the issue tag and the life-cycle bits
    typedef struct packed {
        alloc_req_t req;
        lsu_tag_t   tag;
        logic       issued;
        logic       complete;
    } iq_entry_t;

endpackage

`default_nettype wire

// ==== logic/iq_entry_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface iq_entry_if;

    // queue contents, entry 0 is the oldest
    lsu_pkg::iq_entry_t                entries [lsu_pkg::iq_depth];
    logic [lsu_pkg::iq_depth-1:0]      valid;

    // wake-up matches to be stored at the edge
    logic [lsu_pkg::iq_depth-1:0]      set_rj_ready;
    logic [lsu_pkg::iq_depth-1:0]      set_rk_ready;

    // per-entry decisions
    logic [lsu_pkg::iq_depth-1:0]      permit;
    logic [lsu_pkg::iq_depth-1:0]      opnd_ready;

    // issue selector choice
    logic                              pick_valid;
    lsu_pkg::iq_idx_t                  pick_index;

    modport storage (output entries, valid,
                     input  set_rj_ready, set_rk_ready, pick_valid, pick_index);
    modport wakeup  (input  entries, valid,
                     output opnd_ready, set_rj_ready, set_rk_ready);
    modport order   (input  entries, valid,
                     output permit);
    modport select  (input  entries, opnd_ready, permit,
                     output pick_valid, pick_index);

endinterface

`default_nettype wire

// ==== logic/lsu_iq_storage.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_iq_storage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       alloc_valid,
    input  wire  [1:0]                alloc_num,
    input  wire  lsu_pkg::alloc_req_t alloc_req_0,
    input  wire  lsu_pkg::alloc_req_t alloc_req_1,
    input  wire                       complete_valid,
    input  wire  lsu_pkg::lsu_tag_t   complete_tag,
    iq_entry_if.storage               q,
    output logic                      alloc_ready,
    output logic                      iq_full,
    output logic                      iq_empty
);

    lsu_pkg::iq_entry_t  ent     [lsu_pkg::iq_depth];
    lsu_pkg::iq_entry_t  ent_nxt [lsu_pkg::iq_depth];
    lsu_pkg::alloc_req_t reqs    [lsu_pkg::alloc_width];

    lsu_pkg::iq_cnt_t  cnt;
    lsu_pkg::iq_cnt_t  cnt_after_pop;
    lsu_pkg::lsu_tag_t tag_cnt;
    lsu_pkg::iq_idx_t  pop_idx;
    logic              pop_valid;
    logic              accept;

    assign reqs[0] = alloc_req_0;
    assign reqs[1] = alloc_req_1;

    assign q.entries = ent;

    // occupancy decides which slots hold live entries
    always_comb begin
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            q.valid[i] = (lsu_pkg::iq_cnt_t'(i) < cnt);
        end
    end

    assign iq_full  = (cnt == lsu_pkg::iq_cnt_t'(lsu_pkg::iq_depth));
    assign iq_empty = (cnt == '0);

    // oldest entry whose completion was already recorded leaves this cycle
    always_comb begin
        pop_valid = 1'b0;
        pop_idx   = '0;
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            if (!pop_valid && q.valid[i] && ent[i].complete) begin
                pop_valid = 1'b1;
                pop_idx   = lsu_pkg::iq_idx_t'(i);
            end
        end
    end

    assign cnt_after_pop = cnt - lsu_pkg::iq_cnt_t'(pop_valid);
    // room check counts the slot freed by this cycle's pop
    assign alloc_ready = (cnt_after_pop + lsu_pkg::iq_cnt_t'(alloc_num))
                         <= lsu_pkg::iq_cnt_t'(lsu_pkg::iq_depth);
    assign accept = alloc_valid && alloc_ready;

    always_comb begin
        int slot;
        ent_nxt = ent;
        // issued bit for the selector's pick
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            if (q.pick_valid && q.pick_index == lsu_pkg::iq_idx_t'(i)) begin
                ent_nxt[i].issued = 1'b1;
            end
        end
        // completion by tag
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            if (complete_valid && q.valid[i] && ent[i].issued &&
                ent[i].tag == complete_tag) begin
                ent_nxt[i].complete = 1'b1;
            end
        end
        // store wake-up matches
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            if (q.set_rj_ready[i]) begin
                ent_nxt[i].req.rj_ready = 1'b1;
            end
            if (q.set_rk_ready[i]) begin
                ent_nxt[i].req.rk_ready = 1'b1;
            end
        end
        // compact everything behind the popped entry
        for (int i = 0; i < lsu_pkg::iq_depth - 1; i++) begin
            if (pop_valid && lsu_pkg::iq_idx_t'(i) >= pop_idx) begin
                ent_nxt[i] = ent_nxt[i+1];
            end
        end
        // new operations go to the tail with slot 0 first
        for (int s = 0; s < lsu_pkg::alloc_width; s++) begin
            slot = int'(cnt_after_pop) + s;
            if (accept && s < int'(alloc_num) && slot < lsu_pkg::iq_depth) begin
                ent_nxt[slot].req      = reqs[s];
                ent_nxt[slot].tag      = tag_cnt + lsu_pkg::lsu_tag_t'(s);
                ent_nxt[slot].issued   = 1'b0;
                ent_nxt[slot].complete = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            tag_cnt <= '0;
        end else begin
            cnt <= accept ? cnt_after_pop + lsu_pkg::iq_cnt_t'(alloc_num) : cnt_after_pop;
            if (accept) begin
                tag_cnt <= tag_cnt + lsu_pkg::lsu_tag_t'(alloc_num);
            end
        end
    end

    // entry array takes the merged next state
    always_ff @(posedge clk) begin
        ent <= ent_nxt;
    end

endmodule

`default_nettype wire

// ==== logic/operand_wakeup.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_wakeup (
    iq_entry_if.wakeup                   q,
    input  wire [lsu_pkg::wb_ports-1:0]  wb_valid,
    input  wire lsu_pkg::preg_t          wb_preg_0,
    input  wire lsu_pkg::preg_t          wb_preg_1
);

    lsu_pkg::preg_t wb_preg [lsu_pkg::wb_ports];

    logic [lsu_pkg::iq_depth-1:0] rj_hit;
    logic [lsu_pkg::iq_depth-1:0] rk_hit;

    assign wb_preg[0] = wb_preg_0;
    assign wb_preg[1] = wb_preg_1;

    // compare every source against every write-back port
    always_comb begin
        rj_hit = '0;
        rk_hit = '0;
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            for (int p = 0; p < lsu_pkg::wb_ports; p++) begin
                if (wb_valid[p] && q.entries[i].req.rj == wb_preg[p]) begin
                    rj_hit[i] = 1'b1;
                end
                if (wb_valid[p] && q.entries[i].req.rk == wb_preg[p]) begin
                    rk_hit[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            q.set_rj_ready[i] = q.valid[i] && q.entries[i].req.rj_exist && rj_hit[i];
            q.set_rk_ready[i] = q.valid[i] && q.entries[i].req.rk_exist && rk_hit[i];
            // a match this cycle counts as ready, so the pick need not wait for the edge
            q.opnd_ready[i] = q.valid[i] &&
                (!q.entries[i].req.rj_exist || q.entries[i].req.rj_ready || rj_hit[i]) &&
                (!q.entries[i].req.rk_exist || q.entries[i].req.rk_ready || rk_hit[i]);
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_order_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_order_check (
    iq_entry_if.order q
);

    logic store_pending;
    logic older_incomplete;
    logic barrier_pending;
    logic is_mem;
    logic is_bar;

    // walk from the head, each entry sees only what is older than itself
    always_comb begin
        store_pending    = 1'b0;
        older_incomplete = 1'b0;
        barrier_pending  = 1'b0;
        is_mem           = 1'b0;
        is_bar           = 1'b0;
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            is_mem = (q.entries[i].req.kind == lsu_pkg::kind_load) ||
                     (q.entries[i].req.kind == lsu_pkg::kind_store);
            is_bar = !is_mem;

            q.permit[i] = 1'b0;
            if (q.valid[i] && !q.entries[i].issued && !barrier_pending) begin
                if (is_mem) begin
                    // stores keep program order and loads never pass a store
                    q.permit[i] = !store_pending;
                end else begin
                    // barriers wait for the whole older window to drain
                    q.permit[i] = !older_incomplete;
                end
            end

            if (q.valid[i]) begin
                if (q.entries[i].req.kind == lsu_pkg::kind_store && !q.entries[i].issued) begin
                    store_pending = 1'b1;
                end
                if (!q.entries[i].complete) begin
                    older_incomplete = 1'b1;
                    if (is_bar) begin
                        barrier_pending = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_select (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                fu_ready,
    iq_entry_if.select         q,
    output logic               issue_valid,
    output lsu_pkg::op_kind_t  issue_kind,
    output lsu_pkg::rob_idx_t  issue_rob,
    output lsu_pkg::preg_t     issue_rj,
    output lsu_pkg::preg_t     issue_rk,
    output lsu_pkg::lsu_tag_t  issue_tag
);

    logic             found;
    lsu_pkg::iq_idx_t found_idx;
    lsu_pkg::iq_entry_t pick_ent;

    // lowest index wins, which is the oldest candidate
    always_comb begin
        found     = 1'b0;
        found_idx = '0;
        for (int i = 0; i < lsu_pkg::iq_depth; i++) begin
            if (!found && q.opnd_ready[i] && q.permit[i]) begin
                found     = 1'b1;
                found_idx = lsu_pkg::iq_idx_t'(i);
            end
        end
    end

    // nothing is picked while the unit is busy
    assign q.pick_valid = fu_ready && found;
    assign q.pick_index = found_idx;
    assign pick_ent     = q.entries[found_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= q.pick_valid;
        end
    end

    // operation fields only move when a pick happens
    always_ff @(posedge clk) begin
        if (q.pick_valid) begin
            issue_kind <= pick_ent.req.kind;
            issue_rob  <= pick_ent.req.rob;
            issue_rj   <= pick_ent.req.rj;
            issue_rk   <= pick_ent.req.rk;
            issue_tag  <= pick_ent.tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/lsu_issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_queue (
    input  wire                          clk,
    input  wire                          rst_n,
    // rename side
    input  wire                          alloc_valid,
    input  wire  [1:0]                   alloc_num,
    input  wire  lsu_pkg::alloc_req_t    alloc_req_0,
    input  wire  lsu_pkg::alloc_req_t    alloc_req_1,
    output logic                         alloc_ready,
    output logic                         iq_full,
    output logic                         iq_empty,
    // write-back wake-up
    input  wire  [lsu_pkg::wb_ports-1:0] wb_valid,
    input  wire  lsu_pkg::preg_t         wb_preg_0,
    input  wire  lsu_pkg::preg_t         wb_preg_1,
    // functional unit
    input  wire                          fu_ready,
    input  wire                          complete_valid,
    input  wire  lsu_pkg::lsu_tag_t      complete_tag,
    output logic                         issue_valid,
    output lsu_pkg::op_kind_t            issue_kind,
    output lsu_pkg::rob_idx_t            issue_rob,
    output lsu_pkg::preg_t               issue_rj,
    output lsu_pkg::preg_t               issue_rk,
    output lsu_pkg::lsu_tag_t            issue_tag
);

    iq_entry_if q ();

    lsu_iq_storage u_storage (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc_valid    (alloc_valid),
        .alloc_num      (alloc_num),
        .alloc_req_0    (alloc_req_0),
        .alloc_req_1    (alloc_req_1),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .q              (q.storage),
        .alloc_ready    (alloc_ready),
        .iq_full        (iq_full),
        .iq_empty       (iq_empty)
    );

    // operand readiness and ordering run side by side
    operand_wakeup u_wakeup (
        .q         (q.wakeup),
        .wb_valid  (wb_valid),
        .wb_preg_0 (wb_preg_0),
        .wb_preg_1 (wb_preg_1)
    );

    mem_order_check u_order (
        .q (q.order)
    );

    issue_select u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .fu_ready    (fu_ready),
        .q           (q.select),
        .issue_valid (issue_valid),
        .issue_kind  (issue_kind),
        .issue_rob   (issue_rob),
        .issue_rj    (issue_rj),
        .issue_rk    (issue_rk),
        .issue_tag   (issue_tag)
    );

endmodule

`default_nettype wire

// ==== dv/tb_lsu_issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_issue_queue;

    typedef logic [8*16-1:0] text_t;
    localparam string trace_file = "dv/lsu_iq_trace.txt";

    logic clk;
    logic rst_n;
    logic alloc_valid;
    logic [1:0] alloc_num;
    lsu_pkg::alloc_req_t alloc_req_0;
    lsu_pkg::alloc_req_t alloc_req_1;
    logic [lsu_pkg::wb_ports-1:0] wb_valid;
    lsu_pkg::preg_t wb_preg_0;
    lsu_pkg::preg_t wb_preg_1;
    logic fu_ready;
    logic complete_valid;
    lsu_pkg::lsu_tag_t complete_tag;
    logic alloc_ready;
    logic iq_full;
    logic iq_empty;
    logic issue_valid;
    lsu_pkg::op_kind_t issue_kind;
    lsu_pkg::rob_idx_t issue_rob;
    lsu_pkg::preg_t issue_rj;
    lsu_pkg::preg_t issue_rk;
    lsu_pkg::lsu_tag_t issue_tag;

    // scoreboard state shared by the trace reader and the responder
    lsu_pkg::alloc_req_t pend_alloc [$];
    lsu_pkg::rob_idx_t   seen_rob [$];
    lsu_pkg::op_kind_t   seen_kind [$];
    lsu_pkg::preg_t      seen_rj [$];
    lsu_pkg::preg_t      seen_rk [$];
    lsu_pkg::lsu_tag_t   pend_tag [$];
    int                  pend_due [$];
    // source registers of each allocated operation, looked up by ROB index
    lsu_pkg::preg_t      rj_of_rob [1 << lsu_pkg::rob_w];
    lsu_pkg::preg_t      rk_of_rob [1 << lsu_pkg::rob_w];
    int issue_errs = 0;
    int src_errs = 0;
    int flag_errs = 0;
    int other_errs = 0;
    int limit_cycles = 0;
    int cycle;
    logic fu_d;
    logic bar_busy;
    lsu_pkg::lsu_tag_t bar_tag;
    text_t cur_test = "reset";

    lsu_issue_queue dut0 (
        .clk(clk), .rst_n(rst_n), .alloc_valid(alloc_valid), .alloc_num(alloc_num),
        .alloc_req_0(alloc_req_0), .alloc_req_1(alloc_req_1), .alloc_ready(alloc_ready),
        .iq_full(iq_full), .iq_empty(iq_empty), .wb_valid(wb_valid), .wb_preg_0(wb_preg_0),
        .wb_preg_1(wb_preg_1), .fu_ready(fu_ready), .complete_valid(complete_valid),
        .complete_tag(complete_tag), .issue_valid(issue_valid), .issue_kind(issue_kind),
        .issue_rob(issue_rob), .issue_rj(issue_rj), .issue_rk(issue_rk), .issue_tag(issue_tag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_issue(input text_t test, input lsu_pkg::rob_idx_t exp_rob,
                               input lsu_pkg::op_kind_t exp_kind,
                               input lsu_pkg::rob_idx_t act_rob,
                               input lsu_pkg::op_kind_t act_kind);
        if (exp_rob !== act_rob || exp_kind !== act_kind) begin
            issue_errs++;
            $display("Fail %0s: issue expected rob %0d %s, actual rob %0d %s",
                     test, exp_rob, exp_kind.name(), act_rob, act_kind.name());
        end
    endtask

    task automatic compare_src(input text_t test, input text_t src,
                               input lsu_pkg::preg_t exp, input lsu_pkg::preg_t act);
        if (exp !== act) begin
            src_errs++;
            $display("Fail %0s: %0s expected p%0d, actual p%0d", test, src, exp, act);
        end
    endtask

    task automatic check_flag(input text_t test, input text_t flag, input logic exp,
                              input logic act);
        if (exp !== act) begin
            flag_errs++;
            $display("Fail %0s: %0s expected %b, actual %b", test, flag, exp, act);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // two at a time while at least two are waiting
    task automatic flush_allocs();
        int num;
        logic ok;
        while (pend_alloc.size() > 0) begin
            num = (pend_alloc.size() > 1) ? 2 : 1;
            alloc_req_0 = pend_alloc[0];
            alloc_req_1 = (num == 2) ? pend_alloc[1] : '0;
            alloc_num   = 2'(num);
            alloc_valid = 1'b1;
            ok = 1'b0;
            while (!ok) begin
                @(negedge clk);
                ok = alloc_ready;
                @(posedge clk);
                #1;
            end
            repeat (num) void'(pend_alloc.pop_front());
        end
        alloc_valid = 1'b0;
        alloc_num   = 2'd1;
        alloc_req_0 = '0;
        alloc_req_1 = '0;
    endtask

    task automatic pulse_wb(input int delay, input int port, input lsu_pkg::preg_t preg);
        idle_cycles(delay);
        if (port == 0) begin
            wb_preg_0 = preg;
            wb_valid  = 2'b01;
        end else begin
            wb_preg_1 = preg;
            wb_valid  = 2'b10;
        end
        idle_cycles(1);
        wb_valid = 2'b00;
    endtask

    task automatic match_issues(input int fd);
        int n;
        int cnt;
        int r;
        int kd;
        int tries;
        lsu_pkg::rob_idx_t exp_rob [$];
        lsu_pkg::op_kind_t exp_kind [$];
        n = $fscanf(fd, "%d", cnt);
        for (int i = 0; i < cnt; i++) begin
            n = $fscanf(fd, "%d %d", r, kd);
            exp_rob.push_back(lsu_pkg::rob_idx_t'(r));
            exp_kind.push_back(lsu_pkg::op_kind_t'(kd[1:0]));
        end
        foreach (exp_rob[i]) begin
            tries = 0;
            while (seen_rob.size() == 0 && tries < 200) begin
                idle_cycles(1);
                tries++;
            end
            if (seen_rob.size() == 0) begin
                other_errs++;
                $display("test %0s: rob %0d was never issued", cur_test, exp_rob[i]);
            end else begin
                check_issue(cur_test, exp_rob[i], exp_kind[i], seen_rob.pop_front(),
                            seen_kind.pop_front());
                compare_src(cur_test, "issue_rj", rj_of_rob[exp_rob[i]], seen_rj.pop_front());
                compare_src(cur_test, "issue_rk", rk_of_rob[exp_rob[i]], seen_rk.pop_front());
            end
        end
        // let every issued operation complete and leave the queue
        tries = 0;
        while (!(iq_empty && pend_tag.size() == 0) && tries < 200) begin
            idle_cycles(1);
            tries++;
        end
        if (!iq_empty) begin
            other_errs++;
            $display("test %0s: queue did not drain", cur_test);
        end
        if (seen_rob.size() != 0) begin
            other_errs++;
            $display("test %0s: %0d issues beyond the expected list", cur_test, seen_rob.size());
            seen_rob.delete();
            seen_kind.delete();
            seen_rj.delete();
            seen_rk.delete();
        end
    endtask

    // issue monitor and completion responder share one loop
    initial begin
        int pick;
        void'($urandom(95804));
        complete_valid = 1'b0;
        complete_tag   = '0;
        cycle    = 0;
        fu_d     = 1'b0;
        bar_busy = 1'b0;
        bar_tag  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && issue_valid) begin
                if (!fu_d) begin
                    other_errs++;
                    $display("test %0s: issue while fu_ready was low", cur_test);
                end
                if (bar_busy) begin
                    other_errs++;
                    $display("test %0s: issue while a barrier was incomplete", cur_test);
                end
                if ((issue_kind == lsu_pkg::kind_dbar || issue_kind == lsu_pkg::kind_ibar)) begin
                    if (pend_tag.size() != 0) begin
                        other_errs++;
                        $display("test %0s: barrier issued before older ops completed",
                                 cur_test);
                    end
                    bar_busy = 1'b1;
                    bar_tag  = issue_tag;
                end
                seen_rob.push_back(issue_rob);
                seen_kind.push_back(issue_kind);
                seen_rj.push_back(issue_rj);
                seen_rk.push_back(issue_rk);
                pend_tag.push_back(issue_tag);
                pend_due.push_back(cycle + 1 + int'($urandom % 4));
            end
            @(posedge clk);
            cycle++;
            fu_d = fu_ready;
            #1;
            pick = -1;
            foreach (pend_due[i]) begin
                if (pick < 0 && pend_due[i] <= cycle) pick = i;
            end
            complete_valid = (pick >= 0);
            if (pick >= 0) begin
                complete_tag = pend_tag[pick];
                if (bar_busy && pend_tag[pick] == bar_tag) bar_busy = 1'b0;
                pend_tag.delete(pick);
                pend_due.delete(pick);
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: run still going after %0d cycles", limit_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int fd;
        int n;
        int nlines;
        int a, b, c, d, e, f, g, h;
        logic [8*200-1:0] line;
        text_t word;
        text_t fname;
        lsu_pkg::alloc_req_t req;
        rst_n = 1'b0;
        alloc_valid = 1'b0;
        alloc_num = 2'd1;
        alloc_req_0 = '0;
        alloc_req_1 = '0;
        wb_valid = '0;
        wb_preg_0 = '0;
        wb_preg_1 = '0;
        fu_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(cur_test, "alloc_ready", 1'b1, alloc_ready);
        check_flag(cur_test, "issue_valid", 1'b0, issue_valid);
        check_flag(cur_test, "iq_empty", 1'b1, iq_empty);
        check_flag(cur_test, "iq_full", 1'b0, iq_full);
        idle_cycles(1);
        // watchdog budget grows with the trace length
        nlines = 0;
        fd = $fopen(trace_file, "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open the trace file %0s", trace_file);
        end else begin
            while ($fgets(line, fd) != 0) nlines++;
            $fclose(fd);
            fd = $fopen(trace_file, "r");
        end
        limit_cycles = 40 * (nlines + 1);
        while (fd != 0 && !$feof(fd)) begin
            word = '0;
            n = $fscanf(fd, "%s", word);
            if (n != 1) break;
            if (word != "alloc" && word != "#") flush_allocs();
            case (word)
                "#": n = $fgets(line, fd);
                "test": begin
                    word = '0;
                    n = $fscanf(fd, "%s", word);
                    cur_test = word;
                end
                "alloc": begin
                    n = $fscanf(fd, "%d %d %d %d %d %d %d %d", a, b, c, d, e, f, g, h);
                    req.kind     = lsu_pkg::op_kind_t'(a[1:0]);
                    req.rob      = lsu_pkg::rob_idx_t'(b);
                    req.rj       = lsu_pkg::preg_t'(c);
                    req.rj_exist = d[0];
                    req.rj_ready = e[0];
                    req.rk       = lsu_pkg::preg_t'(f);
                    req.rk_exist = g[0];
                    req.rk_ready = h[0];
                    rj_of_rob[req.rob] = req.rj;
                    rk_of_rob[req.rob] = req.rk;
                    pend_alloc.push_back(req);
                end
                "wb": begin
                    n = $fscanf(fd, "%d %d %d", a, b, c);
                    pulse_wb(a, b, lsu_pkg::preg_t'(c));
                end
                "fu": begin
                    n = $fscanf(fd, "%d", a);
                    fu_ready = a[0];
                end
                "wait": begin
                    n = $fscanf(fd, "%d", a);
                    idle_cycles(a);
                end
                "flag": begin
                    fname = '0;
                    n = $fscanf(fd, "%s %d", fname, a);
                    @(negedge clk);
                    if (fname == "empty") check_flag(cur_test, "iq_empty", a[0], iq_empty);
                    else if (fname == "full") check_flag(cur_test, "iq_full", a[0], iq_full);
                    else if (fname == "ready") begin
                        check_flag(cur_test, "alloc_ready", a[0], alloc_ready);
                    end else begin
                        other_errs++;
                        $display("test %0s: unknown flag %0s in the trace", cur_test, fname);
                    end
                    idle_cycles(1);
                end
                "expect": match_issues(fd);
                default: begin
                    other_errs++;
                    $display("unknown trace keyword %0s", word);
                end
            endcase
        end
        flush_allocs();
        if (fd != 0) $fclose(fd);
        $display("errors: issue %0d, source %0d, flag %0d, other %0d",
                 issue_errs, src_errs, flag_errs, other_errs);
        if (issue_errs + src_errs + flag_errs + other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/lsu_pkg.sv
logic/iq_entry_if.sv
logic/lsu_iq_storage.sv
logic/operand_wakeup.sv
logic/mem_order_check.sv
logic/issue_select.sv
logic/lsu_issue_queue.sv
dv/tb_lsu_issue_queue.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the issue queue testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_lsu_issue_queue -f list.f \
    -o sim_lsu_iq > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_lsu_iq > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1

// ==== dv/lsu_iq_trace.txt ====
# alloc kind rob rj rj_exist rj_ready rk rk_exist rk_ready (kind 0 load 1 store 2 dbar 3 ibar)
# wb delay port preg, fu level, wait cycles, flag name value, expect count then rob kind pairs
test ready_loads
alloc 0 1 10 1 1 0 0 0
alloc 0 2 11 1 1 0 0 0
alloc 0 3 12 1 1 13 1 1
expect 3 1 0 2 0 3 0
test wb_wakeup
alloc 0 5 20 1 0 0 0 0
alloc 0 6 21 1 1 0 0 0
alloc 0 7 22 1 1 23 1 1
wb 8 1 20
expect 3 6 0 7 0 5 0
test store_order
alloc 1 8 30 1 0 31 1 1
alloc 0 9 32 1 1 0 0 0
alloc 1 10 33 1 1 34 1 1
alloc 0 11 35 1 1 0 0 0
wb 6 0 30
expect 4 8 1 9 0 10 1 11 0
test barriers
alloc 0 12 40 1 1 0 0 0
alloc 1 13 41 1 1 42 1 1
alloc 2 14 0 0 0 0 0 0
alloc 0 15 43 1 1 0 0 0
alloc 3 16 0 0 0 0 0 0
alloc 0 17 44 1 1 0 0 0
expect 6 12 0 13 1 14 2 15 0 16 3 17 0
test fill_drain
alloc 0 20 50 1 0 0 0 0
alloc 0 21 50 1 0 0 0 0
alloc 0 22 50 1 0 0 0 0
alloc 0 23 50 1 0 0 0 0
alloc 0 24 50 1 0 0 0 0
alloc 0 25 50 1 0 0 0 0
alloc 0 26 50 1 0 0 0 0
alloc 0 27 50 1 0 0 0 0
flag full 1
flag ready 0
wb 2 0 50
expect 8 20 0 21 0 22 0 23 0 24 0 25 0 26 0 27 0
flag empty 1
test fu_stall
fu 0
alloc 0 50 60 1 1 0 0 0
alloc 0 51 61 1 1 0 0 0
alloc 1 52 62 1 1 63 1 1
alloc 0 53 64 1 1 0 0 0
wait 6
fu 1
expect 4 50 0 51 0 52 1 53 0
